// File: Bender.yml
package:
  name: mem_axi_bridge

sources:
  - hw/mem_axi_pkg.sv
  - hw/mem_msg_if.sv
  - hw/mem_req_fifo.sv
  - hw/axi_single_beat_fsm.sv
  - hw/mem_resp_reg.sv
  - hw/mem_axi_bridge.sv
  - target: test
    files:
      - verif/mem_axi_bridge_tb.sv

// File: hw/axi_single_beat_fsm.sv
// single-beat AXI request engine
`timescale 1ns/1ns

module axi_single_beat_fsm (
  input  logic                clk_i,
  input  logic                reset_i,
  mem_msg_if.consumer         fwd_i,
  mem_msg_if.producer         rev_o,

  output mem_axi_pkg::paddr_t m_axi_awaddr_o,
  output logic                m_axi_awvalid_o,
  output logic [7:0]          m_axi_awlen_o,
  output logic [2:0]          m_axi_awsize_o,
  output logic [1:0]          m_axi_awburst_o,
  input  logic                m_axi_awready_i,

  output mem_axi_pkg::data_t  m_axi_wdata_o,
  output mem_axi_pkg::strb_t  m_axi_wstrb_o,
  output logic                m_axi_wlast_o,
  output logic                m_axi_wvalid_o,
  input  logic                m_axi_wready_i,

  input  logic                m_axi_bvalid_i,
  output logic                m_axi_bready_o,

  output mem_axi_pkg::paddr_t m_axi_araddr_o,
  output logic                m_axi_arvalid_o,
  output logic [7:0]          m_axi_arlen_o,
  output logic [2:0]          m_axi_arsize_o,
  output logic [1:0]          m_axi_arburst_o,
  input  logic                m_axi_arready_i,

  input  mem_axi_pkg::data_t  m_axi_rdata_i,
  input  logic                m_axi_rvalid_i,
  output logic                m_axi_rready_o
);
  import mem_axi_pkg::*;

  typedef enum logic [2:0] {
    e_idle,
    e_write,
    e_wresp,
    e_read,
    e_rdata
  } state_e;

  state_e state_r;
  state_e state_n;
  logic aw_sent_r;
  logic w_sent_r;
  logic aw_hs;
  logic w_hs;
  logic rev_hs;
  logic req_write;
  logic [2:0] lane;

  assign req_write = fwd_i.msg_type inside {e_mem_wr, e_mem_uc_wr};
  assign lane = fwd_i.addr[2:0];

  // request fields stay on the FIFO head until the response pops it
  assign m_axi_awaddr_o = fwd_i.addr;
  assign m_axi_awlen_o = 8'd0;
  assign m_axi_awsize_o = fwd_i.size;
  assign m_axi_awburst_o = axi_burst_incr;
  assign m_axi_wdata_o = fwd_i.data;
  assign m_axi_wlast_o = 1'b1; // always one beat
  assign m_axi_araddr_o = fwd_i.addr;
  assign m_axi_arlen_o = 8'd0;
  assign m_axi_arsize_o = fwd_i.size;
  assign m_axi_arburst_o = axi_burst_incr;

  // byte mask moved to the addressed lane
  always_comb begin
    case (fwd_i.size)
      e_size_1: m_axi_wstrb_o = strb_t'('h01) << lane;
      e_size_2: m_axi_wstrb_o = strb_t'('h03) << lane;
      e_size_4: m_axi_wstrb_o = strb_t'('h0f) << lane;
      default:  m_axi_wstrb_o = '1; // full word
    endcase
  end

  assign m_axi_awvalid_o = (state_r == e_write) & ~aw_sent_r;
  assign m_axi_wvalid_o = (state_r == e_write) & ~w_sent_r;
  assign m_axi_arvalid_o = (state_r == e_read);
  assign aw_hs = m_axi_awvalid_o & m_axi_awready_i;
  assign w_hs = m_axi_wvalid_o & m_axi_wready_i;

  // response side only moves when the response buffer can take it
  assign m_axi_bready_o = (state_r == e_wresp) & rev_o.ready;
  assign m_axi_rready_o = (state_r == e_rdata) & rev_o.ready;
  assign rev_o.v = ((state_r == e_wresp) & m_axi_bvalid_i)
                 | ((state_r == e_rdata) & m_axi_rvalid_i);
  assign rev_hs = rev_o.v & rev_o.ready;

  assign rev_o.msg_type = fwd_i.msg_type;
  assign rev_o.size = fwd_i.size;
  assign rev_o.addr = fwd_i.addr;
  assign rev_o.data = m_axi_rdata_i;

  assign fwd_i.ready = rev_hs; // pop request with its response

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (fwd_i.v) begin
          state_n = req_write ? e_write : e_read;
        end
      end
      e_write: begin
        if ((aw_sent_r | aw_hs) & (w_sent_r | w_hs)) begin
          state_n = e_wresp;
        end
      end
      e_read: begin
        if (m_axi_arready_i) begin
          state_n = e_rdata;
        end
      end
      e_wresp, e_rdata: begin
        if (rev_hs) begin
          state_n = e_idle;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      aw_sent_r <= 1'b0;
      w_sent_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (state_r == e_idle) begin
        aw_sent_r <= 1'b0;
        w_sent_r <= 1'b0;
      end else begin
        aw_sent_r <= aw_sent_r | aw_hs;
        w_sent_r <= w_sent_r | w_hs;
      end
    end
  end

  aw_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o);

  aw_ar_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(m_axi_awvalid_o && m_axi_arvalid_o));

endmodule

// File: hw/mem_axi_bridge.sv
// memory stream to AXI4 bridge
`timescale 1ns/1ns

module mem_axi_bridge (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  mem_axi_pkg::mem_msg_type_e mem_fwd_type_i,
  input  mem_axi_pkg::mem_msg_size_e mem_fwd_size_i,
  input  mem_axi_pkg::paddr_t        mem_fwd_addr_i,
  input  mem_axi_pkg::data_t         mem_fwd_data_i,
  input  logic                       mem_fwd_v_i,
  output logic                       mem_fwd_ready_o,

  output mem_axi_pkg::mem_msg_type_e mem_rev_type_o,
  output mem_axi_pkg::mem_msg_size_e mem_rev_size_o,
  output mem_axi_pkg::paddr_t        mem_rev_addr_o,
  output mem_axi_pkg::data_t         mem_rev_data_o,
  output logic                       mem_rev_v_o,
  input  logic                       mem_rev_ready_i,

  output mem_axi_pkg::paddr_t        m_axi_awaddr_o,
  output logic                       m_axi_awvalid_o,
  output logic [7:0]                 m_axi_awlen_o,
  output logic [2:0]                 m_axi_awsize_o,
  output logic [1:0]                 m_axi_awburst_o,
  input  logic                       m_axi_awready_i,

  output mem_axi_pkg::data_t         m_axi_wdata_o,
  output mem_axi_pkg::strb_t         m_axi_wstrb_o,
  output logic                       m_axi_wlast_o,
  output logic                       m_axi_wvalid_o,
  input  logic                       m_axi_wready_i,

  input  logic                       m_axi_bvalid_i,
  output logic                       m_axi_bready_o,

  output mem_axi_pkg::paddr_t        m_axi_araddr_o,
  output logic                       m_axi_arvalid_o,
  output logic [7:0]                 m_axi_arlen_o,
  output logic [2:0]                 m_axi_arsize_o,
  output logic [1:0]                 m_axi_arburst_o,
  input  logic                       m_axi_arready_i,

  input  mem_axi_pkg::data_t         m_axi_rdata_i,
  input  logic                       m_axi_rvalid_i,
  output logic                       m_axi_rready_o
);

  mem_msg_if fwd_if ();
  mem_msg_if rev_if ();

  // incoming requests wait here
  mem_req_fifo req_fifo (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .mem_fwd_type_i  (mem_fwd_type_i),
    .mem_fwd_size_i  (mem_fwd_size_i),
    .mem_fwd_addr_i  (mem_fwd_addr_i),
    .mem_fwd_data_i  (mem_fwd_data_i),
    .mem_fwd_v_i     (mem_fwd_v_i),
    .mem_fwd_ready_o (mem_fwd_ready_o),
    .fwd_o           (fwd_if.producer)
  );

  axi_single_beat_fsm axi_fsm (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fwd_i           (fwd_if.consumer),
    .rev_o           (rev_if.producer),
    .m_axi_awaddr_o  (m_axi_awaddr_o),
    .m_axi_awvalid_o (m_axi_awvalid_o),
    .m_axi_awlen_o   (m_axi_awlen_o),
    .m_axi_awsize_o  (m_axi_awsize_o),
    .m_axi_awburst_o (m_axi_awburst_o),
    .m_axi_awready_i (m_axi_awready_i),
    .m_axi_wdata_o   (m_axi_wdata_o),
    .m_axi_wstrb_o   (m_axi_wstrb_o),
    .m_axi_wlast_o   (m_axi_wlast_o),
    .m_axi_wvalid_o  (m_axi_wvalid_o),
    .m_axi_wready_i  (m_axi_wready_i),
    .m_axi_bvalid_i  (m_axi_bvalid_i),
    .m_axi_bready_o  (m_axi_bready_o),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_arlen_o   (m_axi_arlen_o),
    .m_axi_arsize_o  (m_axi_arsize_o),
    .m_axi_arburst_o (m_axi_arburst_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rready_o  (m_axi_rready_o)
  );

  mem_resp_reg resp_reg (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rev_i           (rev_if.consumer),
    .mem_rev_type_o  (mem_rev_type_o),
    .mem_rev_size_o  (mem_rev_size_o),
    .mem_rev_addr_o  (mem_rev_addr_o),
    .mem_rev_data_o  (mem_rev_data_o),
    .mem_rev_v_o     (mem_rev_v_o),
    .mem_rev_ready_i (mem_rev_ready_i)
  );

endmodule

// File: hw/mem_axi_pkg.sv
// memory bridge shared definitions
package mem_axi_pkg;

  // physical address and data widths
  localparam int PADDR_W = 40;
  localparam int DATA_W = 64;
  localparam int STRB_W = 8; // one strobe per data byte

  // AXI burst encoding for INCR
  localparam logic [1:0] axi_burst_incr = 2'b01;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // request kinds, both write codes mean a store
  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_type_e;

  // encoded as log2 of the byte count, same as AxSIZE
  typedef enum logic [2:0] {
    e_size_1 = 3'd0,
    e_size_2 = 3'd1,
    e_size_4 = 3'd2,
    e_size_8 = 3'd3
  } mem_msg_size_e;

endpackage

// File: hw/mem_msg_if.sv
// memory message stream interface
`timescale 1ns/1ns

interface mem_msg_if;
  import mem_axi_pkg::*;

  mem_msg_type_e msg_type;
  mem_msg_size_e size;
  paddr_t addr;
  data_t data;
  logic v;     // held with all fields until the transfer
  logic ready;

  modport producer (
    output msg_type,
    output size,
    output addr,
    output data,
    output v,
    input  ready
  );

  modport consumer (
    input  msg_type,
    input  size,
    input  addr,
    input  data,
    input  v,
    output ready
  );

endinterface

// File: hw/mem_req_fifo.sv
// two-entry request buffer
`timescale 1ns/1ns

module mem_req_fifo (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  mem_axi_pkg::mem_msg_type_e mem_fwd_type_i,
  input  mem_axi_pkg::mem_msg_size_e mem_fwd_size_i,
  input  mem_axi_pkg::paddr_t        mem_fwd_addr_i,
  input  mem_axi_pkg::data_t         mem_fwd_data_i,
  input  logic                       mem_fwd_v_i,
  output logic                       mem_fwd_ready_o,
  mem_msg_if.producer                fwd_o
);
  import mem_axi_pkg::*;

  mem_msg_type_e type_mem [2];
  mem_msg_size_e size_mem [2];
  paddr_t addr_mem [2];
  data_t data_mem [2];

  logic wr_ptr_r;
  logic rd_ptr_r;
  logic [1:0] count_r;
  logic push;
  logic pop;

  assign mem_fwd_ready_o = (count_r != 2'd2);
  assign push = mem_fwd_v_i & mem_fwd_ready_o;
  assign pop = fwd_o.v & fwd_o.ready;

  // oldest entry goes out
  assign fwd_o.v = (count_r != 2'd0);
  assign fwd_o.msg_type = type_mem[rd_ptr_r];
  assign fwd_o.size = size_mem[rd_ptr_r];
  assign fwd_o.addr = addr_mem[rd_ptr_r];
  assign fwd_o.data = data_mem[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (push) begin
      type_mem[wr_ptr_r] <= mem_fwd_type_i;
      size_mem[wr_ptr_r] <= mem_fwd_size_i;
      addr_mem[wr_ptr_r] <= mem_fwd_addr_i;
      data_mem[wr_ptr_r] <= mem_fwd_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      count_r <= count_r + 2'(push) - 2'(pop); // both at once keeps the count
    end
  end

  count_max_a: assert property (@(posedge clk_i) disable iff (reset_i)
    count_r <= 2'd2);

endmodule

// File: hw/mem_resp_reg.sv
// one-entry response buffer
`timescale 1ns/1ns

module mem_resp_reg (
  input  logic                       clk_i,
  input  logic                       reset_i,
  mem_msg_if.consumer                rev_i,
  output mem_axi_pkg::mem_msg_type_e mem_rev_type_o,
  output mem_axi_pkg::mem_msg_size_e mem_rev_size_o,
  output mem_axi_pkg::paddr_t        mem_rev_addr_o,
  output mem_axi_pkg::data_t         mem_rev_data_o,
  output logic                       mem_rev_v_o,
  input  logic                       mem_rev_ready_i
);
  import mem_axi_pkg::*;

  mem_msg_type_e type_r;
  mem_msg_size_e size_r;
  paddr_t addr_r;
  data_t data_r;
  logic valid_r;
  logic load;

  // free, or draining this cycle
  assign rev_i.ready = ~valid_r | mem_rev_ready_i;
  assign load = rev_i.v & rev_i.ready;

  always_ff @(posedge clk_i) begin
    if (load) begin
      type_r <= rev_i.msg_type;
      size_r <= rev_i.size;
      addr_r <= rev_i.addr;
      data_r <= rev_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= 1'b0;
    end else if (load) begin
      valid_r <= 1'b1;
    end else if (mem_rev_ready_i) begin
      valid_r <= 1'b0;
    end
  end

  assign mem_rev_type_o = type_r;
  assign mem_rev_size_o = size_r;
  assign mem_rev_addr_o = addr_r;
  assign mem_rev_data_o = data_r;
  assign mem_rev_v_o = valid_r;

  hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_rev_v_o && !mem_rev_ready_i |=> mem_rev_v_o && $stable(mem_rev_data_o)
      && $stable(mem_rev_addr_o) && $stable(mem_rev_type_o) && $stable(mem_rev_size_o));

endmodule

// File: mem_axi_bridge.f
hw/mem_axi_pkg.sv
hw/mem_msg_if.sv
hw/mem_req_fifo.sv
hw/axi_single_beat_fsm.sv
hw/mem_resp_reg.sv
hw/mem_axi_bridge.sv
verif/mem_axi_bridge_tb.sv

// File: verif/mem_axi_bridge_tb.sv
// bridge testbench
`timescale 1ns/1ns

module mem_axi_bridge_tb;
  import mem_axi_pkg::*;

  localparam int TIMEOUT = 500; // cycles per wait loop

  logic clk_i;
  logic reset_i;
  mem_msg_type_e mem_fwd_type_i, mem_rev_type_o;
  mem_msg_size_e mem_fwd_size_i, mem_rev_size_o;
  paddr_t mem_fwd_addr_i, mem_rev_addr_o, m_axi_awaddr_o, m_axi_araddr_o;
  data_t mem_fwd_data_i, mem_rev_data_o, m_axi_wdata_o, m_axi_rdata_i;
  strb_t m_axi_wstrb_o;
  logic [7:0] m_axi_awlen_o, m_axi_arlen_o;
  logic [2:0] m_axi_awsize_o, m_axi_arsize_o;
  logic [1:0] m_axi_awburst_o, m_axi_arburst_o;
  logic mem_fwd_v_i, mem_fwd_ready_o, mem_rev_v_o, mem_rev_ready_i;
  logic m_axi_awvalid_o, m_axi_awready_i, m_axi_wlast_o, m_axi_wvalid_o, m_axi_wready_i;
  logic m_axi_bvalid_i, m_axi_bready_o, m_axi_arvalid_o, m_axi_arready_i;
  logic m_axi_rvalid_i, m_axi_rready_o;

  // test table with one entry per line of the tests file
  string name_q[$];
  int type_q[$];
  int bytes_q[$];
  paddr_t addr_q[$];
  data_t wdata_q[$];
  data_t rdata_q[$];
  int axi_q[$]; // requests still owed an AXI response
  int rsp_q[$]; // requests still owed a stream response

  logic [7:0] mem [paddr_t]; // byte-wide AXI memory
  logic [31:0] lfsr = 32'd96943;
  int errors = 0;
  int responses = 0;
  bit stalled = 0;
  bit aw_done = 0;
  bit w_done = 0;
  bit b_pend = 0;
  bit r_pend = 0;
  bit hold_v = 0;
  logic [108:0] held; // type, size, addr and data
  paddr_t aw_addr_r, r_addr;
  data_t w_data_r;
  strb_t w_strb_r;

  mem_axi_bridge dut_i (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic rand_bit();
    lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
    return lfsr[0];
  endfunction

  function automatic bit is_write(int t);
    return t == 1 || t == 3;
  endfunction

  // one strobe per byte from the addressed lane upward
  function automatic strb_t lane_mask(int nbytes, paddr_t a);
    strb_t m = '0;
    for (int i = 0; i < nbytes; i++) begin
      if (a[2:0] + i < 8) m[a[2:0] + i] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [7:0] fill_byte(paddr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32];
  endfunction

  function automatic data_t read_word(paddr_t a);
    data_t d;
    paddr_t k;
    for (int i = 0; i < 8; i++) begin
      k = {a[39:3], 3'(i)};
      d[8*i +: 8] = mem.exists(k) ? mem[k] : fill_byte(k);
    end
    return d;
  endfunction

  task automatic report_mismatch(string test, string what, logic [63:0] exp, logic [63:0] act);
    $display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
    errors++;
  endtask

  task automatic report_error(string why);
    $display("ERROR: %s", why);
    errors++;
  endtask

  task automatic check_addr(string ch, paddr_t a, logic [7:0] len, logic [2:0] size,
                            logic [1:0] burst, bit wr);
    int idx;
    if (axi_q.size() == 0) begin
      report_error({ch, " address handshake with no request outstanding"});
    end else begin
      idx = axi_q[0];
      if (is_write(type_q[idx]) != wr) report_error({ch, " used for the wrong request kind"});
      if (a !== addr_q[idx]) report_mismatch(name_q[idx], {ch, "addr"}, addr_q[idx], a);
      if (len !== 8'd0) report_mismatch(name_q[idx], {ch, "len"}, 0, len);
      if (burst !== axi_burst_incr)
        report_mismatch(name_q[idx], {ch, "burst"}, axi_burst_incr, burst);
      if (size !== 3'($clog2(bytes_q[idx])))
        report_mismatch(name_q[idx], {ch, "size"}, $clog2(bytes_q[idx]), size);
    end
  endtask

  task automatic check_w();
    int idx;
    if (axi_q.size() == 0) begin
      report_error("write data handshake with no request outstanding");
    end else begin
      idx = axi_q[0];
      if (m_axi_wstrb_o !== lane_mask(bytes_q[idx], addr_q[idx]))
        report_mismatch(name_q[idx], "wstrb", lane_mask(bytes_q[idx], addr_q[idx]), m_axi_wstrb_o);
      if (m_axi_wdata_o !== wdata_q[idx])
        report_mismatch(name_q[idx], "wdata", wdata_q[idx], m_axi_wdata_o);
      if (m_axi_wlast_o !== 1'b1) report_mismatch(name_q[idx], "wlast", 1, m_axi_wlast_o);
    end
  endtask

  task automatic check_response();
    int idx;
    if (rsp_q.size() == 0) begin
      report_error("response with no request outstanding");
    end else begin
      idx = rsp_q.pop_front();
      responses++;
      if (mem_rev_type_o !== 2'(type_q[idx]))
        report_mismatch(name_q[idx], "type", type_q[idx], mem_rev_type_o);
      if (mem_rev_size_o !== 3'($clog2(bytes_q[idx])))
        report_mismatch(name_q[idx], "size", $clog2(bytes_q[idx]), mem_rev_size_o);
      if (mem_rev_addr_o !== addr_q[idx])
        report_mismatch(name_q[idx], "addr", addr_q[idx], mem_rev_addr_o);
      if (!is_write(type_q[idx]) && mem_rev_data_o !== rdata_q[idx])
        report_mismatch(name_q[idx], "rdata", rdata_q[idx], mem_rev_data_o);
    end
  endtask

  // inputs change on the falling edge and outputs are sampled 1 ns later
  always @(negedge clk_i) begin
    if (!reset_i) begin
      mem_rev_ready_i = rand_bit() | rand_bit(); // low about a quarter of the time
      m_axi_awready_i = rand_bit();
      m_axi_wready_i = rand_bit();
      m_axi_arready_i = rand_bit();
      if (!b_pend) m_axi_bvalid_i = 1'b0;
      else if (!m_axi_bvalid_i) m_axi_bvalid_i = rand_bit();
      if (!r_pend) begin
        m_axi_rvalid_i = 1'b0;
      end else if (!m_axi_rvalid_i) begin
        m_axi_rvalid_i = rand_bit();
        m_axi_rdata_i = read_word(r_addr);
      end
      #1;
      if (hold_v && !mem_rev_v_o) report_error("response valid dropped while stalled");
      else if (hold_v && {mem_rev_type_o, mem_rev_size_o, mem_rev_addr_o, mem_rev_data_o} !== held)
        report_error("response outputs changed while stalled");
      hold_v = mem_rev_v_o && !mem_rev_ready_i;
      held = {mem_rev_type_o, mem_rev_size_o, mem_rev_addr_o, mem_rev_data_o};
      if (mem_rev_v_o && mem_rev_ready_i) check_response(); // taken at the next rising edge
      if (m_axi_awvalid_o && m_axi_awready_i) begin
        check_addr("aw", m_axi_awaddr_o, m_axi_awlen_o, m_axi_awsize_o, m_axi_awburst_o, 1'b1);
        aw_addr_r = m_axi_awaddr_o;
        aw_done = 1;
      end
      if (m_axi_wvalid_o && m_axi_wready_i) begin
        check_w();
        w_data_r = m_axi_wdata_o;
        w_strb_r = m_axi_wstrb_o;
        w_done = 1;
      end
      if (aw_done && w_done) begin
        for (int i = 0; i < 8; i++) begin
          if (w_strb_r[i]) mem[{aw_addr_r[39:3], 3'(i)}] = w_data_r[8*i +: 8];
        end
        aw_done = 0;
        w_done = 0;
        b_pend = 1;
      end
      if (m_axi_arvalid_o && m_axi_arready_i) begin
        check_addr("ar", m_axi_araddr_o, m_axi_arlen_o, m_axi_arsize_o, m_axi_arburst_o, 1'b0);
        r_addr = m_axi_araddr_o;
        r_pend = 1;
      end
      if ((m_axi_bvalid_i && m_axi_bready_o) || (m_axi_rvalid_i && m_axi_rready_o)) begin
        b_pend = 0;
        r_pend = 0;
        if (axi_q.size() > 0) void'(axi_q.pop_front());
      end
    end
  end

  task automatic send_req(int idx);
    int waited = 0;
    mem_fwd_type_i = mem_msg_type_e'(type_q[idx]);
    mem_fwd_size_i = mem_msg_size_e'($clog2(bytes_q[idx]));
    mem_fwd_addr_i = addr_q[idx];
    mem_fwd_data_i = wdata_q[idx];
    mem_fwd_v_i = 1'b1;
    axi_q.push_back(idx);
    rsp_q.push_back(idx);
    while (!mem_fwd_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!mem_fwd_ready_o) begin
      report_error({"request ", name_q[idx], " was never accepted"});
      stalled = 1;
    end
    @(negedge clk_i);
    mem_fwd_v_i = 1'b0;
  endtask

  initial begin
    int fd;
    int t;
    int nb;
    int waited;
    string line;
    string nm;
    paddr_t a;
    data_t wd;
    data_t rd;
    clk_i = 1'b0;
    reset_i = 1'b1;
    mem_fwd_type_i = e_mem_rd;
    mem_fwd_size_i = e_size_1;
    mem_fwd_addr_i = '0;
    mem_fwd_data_i = '0;
    mem_fwd_v_i = 1'b0;
    mem_rev_ready_i = 1'b0;
    m_axi_awready_i = 1'b0;
    m_axi_wready_i = 1'b0;
    m_axi_bvalid_i = 1'b0;
    m_axi_arready_i = 1'b0;
    m_axi_rdata_i = '0;
    m_axi_rvalid_i = 1'b0;
    fd = $fopen("verif/mem_axi_tests.txt", "r");
    if (fd == 0) begin
      report_error("cannot open verif/mem_axi_tests.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#" &&
            $sscanf(line, "%s %d %d %h %h %h", nm, t, nb, a, wd, rd) == 6) begin
          name_q.push_back(nm);
          type_q.push_back(t);
          bytes_q.push_back(nb);
          addr_q.push_back(a);
          wdata_q.push_back(wd);
          rdata_q.push_back(rd);
        end
      end
      $fclose(fd);
    end
    if (name_q.size() == 0) report_error("no tests were read");
    repeat (4) @(negedge clk_i);
    reset_i <= 1'b0; // the AXI model still sees reset on this edge
    #1;
    if ({mem_rev_v_o, m_axi_awvalid_o, m_axi_wvalid_o, m_axi_arvalid_o, m_axi_bready_o,
         m_axi_rready_o, mem_fwd_ready_o} !== 7'b0000001)
      report_mismatch("reset", "valids/readies", 7'b0000001, {mem_rev_v_o, m_axi_awvalid_o,
        m_axi_wvalid_o, m_axi_arvalid_o, m_axi_bready_o, m_axi_rready_o, mem_fwd_ready_o});
    @(negedge clk_i);
    for (int i = 0; i < name_q.size(); i++) begin
      if (!stalled) send_req(i);
    end
    waited = 0;
    while (!stalled && responses < name_q.size() && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (responses < name_q.size()) report_error("timed out waiting for responses");
    repeat (20) @(negedge clk_i); // late duplicates would show here
    if (responses != name_q.size()) report_error("response count differs from request count");
    $display("tests %0d, responses %0d, errors %0d", name_q.size(), responses, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verif/mem_axi_tests.txt
# name type(0 rd 1 wr 2 uc_rd 3 uc_wr) size_bytes addr_hex wdata_hex expected_rdata_hex
# sub-word write data sits in its byte lanes, write lines carry rdata 0
wr8_a   1 8 0000001000 0123456789abcdef 0000000000000000
rd8_a   0 8 0000001000 0000000000000000 0123456789abcdef
ucwr8_b 3 8 8000002008 fedcba9876543210 0000000000000000
ucrd8_b 2 8 8000002008 0000000000000000 fedcba9876543210
wr8_c   1 8 0000003000 0000000000000000 0000000000000000
wr1_c0  1 1 0000003000 00000000000000aa 0000000000000000
wr1_c5  3 1 0000003005 0000bb0000000000 0000000000000000
wr2_c2  1 2 0000003002 00000000cccc0000 0000000000000000
wr2_c6  1 2 0000003006 dddd000000000000 0000000000000000
rd8_c   0 8 0000003000 0000000000000000 ddddbb00cccc00aa
wr8_d   1 8 0000004010 1111111111111111 0000000000000000
wr4_d0  3 4 0000004010 0000000022222222 0000000000000000
wr4_d4  1 4 0000004014 3333333300000000 0000000000000000
wr1_d3  1 1 0000004013 0000000044000000 0000000000000000
rd8_d   2 8 0000004010 0000000000000000 3333333344222222
wr8_e   1 8 ff00000ff8 a5a5a5a5a5a5a5a5 0000000000000000
wr1_e1  1 1 ff00000ff9 0000000000005a00 0000000000000000
wr2_e4  3 2 ff00000ffc 0000c3c300000000 0000000000000000
rd8_e   0 8 ff00000ff8 0000000000000000 a5a5c3c3a5a55aa5
rd8_a2  2 8 0000001000 0000000000000000 0123456789abcdef
rd4_a   0 4 0000001004 0000000000000000 0123456789abcdef
wr8_f   1 8 0000005000 0f1e2d3c4b5a6978 0000000000000000
rd8_f   0 8 0000005000 0000000000000000 0f1e2d3c4b5a6978
